/* source/m92_defines.svh */
// Shared widths and constants for the M92 board glue
// SDRAM and hiscore address widths, DIP download index and bank count,
// and the SDRAM page that holds CPU work RAM
`ifndef M92_DEFINES_SVH
`define M92_DEFINES_SVH

// SDRAM byte address and channel word widths
`define M92_SDR_ADDR_W   25
`define M92_SDR_DATA_W   16

// Hiscore engine byte address width
`define M92_HS_ADDR_W    20

// Host download slot that carries the DIP settings
`define M92_DIP_INDEX    8'd254
`define M92_DIP_BANKS    3

// Upper nine SDRAM address bits of CPU work RAM
`define M92_CPU_RAM_PAGE 9'h00A

`endif

/* source/m92_mem_pkg.sv */
// Memory-side types for SDRAM channel 3 and the hiscore bridge
// Channel address, data and byte enables, hiscore address, channel owner
`default_nettype none

`include "m92_defines.svh"

package m92_mem_pkg;

    typedef logic [`M92_SDR_ADDR_W-1:0] sdr_addr_t;
    typedef logic [`M92_SDR_DATA_W-1:0] sdr_data_t;
    // Bit 1 enables the high byte
    typedef logic [1:0]                 sdr_be_t;
    typedef logic [`M92_HS_ADDR_W-1:0]  hs_addr_t;
    typedef logic [7:0]                 byte_t;

    // Who holds channel 3 outside ROM loading
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_HS,
        OWN_CPU
    } ch3_owner_t;

endpackage

`default_nettype wire

/* source/m92_input_pkg.sv */
// Player input types and button bit positions of the pad words
`default_nettype none

package m92_input_pkg;

    // Raw pad word from keyboard or joystick
    typedef logic [15:0] pad_t;
    // Game controls of one player, the low ten pad bits
    typedef logic [9:0]  player_t;
    // DIP bank, a zero bit means the switch is on
    typedef logic [7:0]  dip_bank_t;

    localparam int BTN_START      = 10;
    localparam int BTN_COIN       = 11;
    localparam int BTN_START2_ALT = 12;
    localparam int BTN_PAUSE      = 13;

endpackage

`default_nettype wire

/* source/ioctl_dip_decoder.sv */
// DIP switch capture from the host download stream
// Holds the DIP banks and presents them as one concatenated word
`timescale 1ns/1ps
`default_nettype none

`include "m92_defines.svh"

module ioctl_dip_decoder (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire                         ioctl_wr,
    input  wire m92_mem_pkg::byte_t     ioctl_index,
    input  wire m92_mem_pkg::sdr_addr_t ioctl_addr,
    input  wire m92_mem_pkg::byte_t     ioctl_dout,
    output wire [`M92_DIP_BANKS*8-1:0]  dip_sw
);

    localparam int SEL_W = $clog2(`M92_DIP_BANKS);

    m92_input_pkg::dip_bank_t banks [`M92_DIP_BANKS];
    logic dip_wr;

    assign dip_wr = ioctl_wr && (ioctl_index == `M92_DIP_INDEX)
                    && (ioctl_addr < `M92_DIP_BANKS);

    // All ones after reset, every switch off
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `M92_DIP_BANKS; i++) begin
                banks[i] <= '1;
            end
        end else if (dip_wr) begin
            banks[ioctl_addr[SEL_W-1:0]] <= ioctl_dout;
        end
    end

    // Bank 0 in the low byte
    for (genvar g = 0; g < `M92_DIP_BANKS; g++) begin : g_pack
        assign dip_sw[g*8 +: 8] = banks[g];

        // A bank only moves on a DIP download write to its own address
        a_dip_stable : assert property (@(posedge clk_sys) disable iff (!rst_n)
            $changed(dip_sw[g*8 +: 8]) |-> $past(ioctl_wr
                && (ioctl_index == `M92_DIP_INDEX) && (ioctl_addr == g)))
            else $error("DIP bank %0d changed without a download write to it", g);
    end

endmodule

`default_nettype wire

/* source/arcade_input_mapper.sv */
// Keyboard and joystick merge for four players
// Registered player controls, start buttons, coin and pause
`timescale 1ns/1ps
`default_nettype none

`include "m92_defines.svh"

module arcade_input_mapper (
    input  wire                          clk_sys,
    input  wire                          rst_n,
    input  wire m92_input_pkg::pad_t     joystick_p1,
    input  wire m92_input_pkg::pad_t     joystick_p2,
    input  wire m92_input_pkg::pad_t     joystick_p3,
    input  wire m92_input_pkg::pad_t     joystick_p4,
    input  wire m92_input_pkg::pad_t     keyboard_p1,
    input  wire m92_input_pkg::pad_t     keyboard_p2,
    input  wire m92_input_pkg::pad_t     keyboard_p3,
    input  wire m92_input_pkg::pad_t     keyboard_p4,
    input  wire [3:0]                    key_start,
    input  wire [3:0]                    key_coin,
    input  wire                          key_pause,
    output m92_input_pkg::player_t       p1_input,
    output m92_input_pkg::player_t       p2_input,
    output m92_input_pkg::player_t       p3_input,
    output m92_input_pkg::player_t       p4_input,
    output logic [3:0]                   start_buttons,
    output logic                         coin,
    output logic                         pause
);

    m92_input_pkg::pad_t combined;
    logic [3:0] start_next;

    // Any joystick can give the shared buttons
    assign combined = joystick_p1 | joystick_p2 | joystick_p3 | joystick_p4;

    assign start_next[0] = joystick_p1[m92_input_pkg::BTN_START] | key_start[0];
    assign start_next[1] = joystick_p2[m92_input_pkg::BTN_START]
                           | combined[m92_input_pkg::BTN_START2_ALT] | key_start[1];
    assign start_next[2] = joystick_p3[m92_input_pkg::BTN_START] | key_start[2];
    assign start_next[3] = joystick_p4[m92_input_pkg::BTN_START] | key_start[3];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            p1_input      <= '0;
            p2_input      <= '0;
            p3_input      <= '0;
            p4_input      <= '0;
            start_buttons <= '0;
            coin          <= 1'b0;
            pause         <= 1'b0;
        end else begin
            p1_input      <= m92_input_pkg::player_t'(keyboard_p1 | joystick_p1);
            p2_input      <= m92_input_pkg::player_t'(keyboard_p2 | joystick_p2);
            p3_input      <= m92_input_pkg::player_t'(keyboard_p3 | joystick_p3);
            p4_input      <= m92_input_pkg::player_t'(keyboard_p4 | joystick_p4);
            start_buttons <= start_next;
            coin          <= combined[m92_input_pkg::BTN_COIN] | (|key_coin);
            pause         <= combined[m92_input_pkg::BTN_PAUSE] | key_pause;
        end
    end

endmodule

`default_nettype wire

/* source/hiscore_ram_bridge.sv */
// Hiscore access bridge into CPU work RAM
// Edge detect of the byte enables, toggle request towards channel 3,
// byte select of the returned word
`timescale 1ns/1ps
`default_nettype none

`include "m92_defines.svh"

module hiscore_ram_bridge (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire m92_mem_pkg::hs_addr_t  hs_address,
    input  wire m92_mem_pkg::byte_t     hs_data_in,
    input  wire                         hs_read_enable,
    input  wire                         hs_write_enable,
    output m92_mem_pkg::byte_t          hs_data_out,
    output logic                        hs_data_ready,
    output m92_mem_pkg::sdr_addr_t      hs_sdr_addr,
    output m92_mem_pkg::sdr_be_t        hs_sdr_be,
    output m92_mem_pkg::sdr_data_t      hs_sdr_din,
    output logic                        hs_rq,
    input  wire                         hs_ack,
    input  wire m92_mem_pkg::sdr_data_t sdr_ch3_dout
);

    logic rd_lat;
    logic wr_lat;
    logic active;
    logic start;
    logic done;

    // Edges during an access are dropped
    assign start = !active && ((hs_write_enable && !wr_lat)
                               || (hs_read_enable && !rd_lat));
    assign done  = active && (hs_rq == hs_ack);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rd_lat        <= 1'b0;
            wr_lat        <= 1'b0;
            active        <= 1'b0;
            hs_rq         <= 1'b0;
            hs_data_ready <= 1'b0;
        end else begin
            rd_lat        <= hs_read_enable;
            wr_lat        <= hs_write_enable;
            hs_data_ready <= done;
            if (start) begin
                hs_rq  <= ~hs_rq;
                active <= 1'b1;
            end else if (done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (start) begin
            hs_sdr_addr <= {`M92_CPU_RAM_PAGE, hs_address[15:0]};
            // Reads carry no byte enable
            hs_sdr_be   <= hs_write_enable ? {hs_address[0], ~hs_address[0]} : 2'b00;
            hs_sdr_din  <= {hs_data_in, hs_data_in};
        end
        if (done) begin
            hs_data_out <= hs_sdr_addr[0] ? sdr_ch3_dout[15:8] : sdr_ch3_dout[7:0];
        end
    end

    // The ack never comes with the request toggle, so ready ends an access
    // that has run for at least two cycles
    a_ready_in_access : assert property (@(posedge clk_sys) disable iff (!rst_n)
        hs_data_ready |-> $past(active) && $past(active, 2))
        else $error("hiscore ready outside an access");

endmodule

`default_nettype wire

/* source/sdram_ch3_arbiter.sv */
// SDRAM channel 3 sharing between ROM loader, hiscore bridge and CPU
// Owner FSM, pending CPU request and latched request fields
`timescale 1ns/1ps
`default_nettype none

`include "m92_defines.svh"

module sdram_ch3_arbiter (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire                         rom_load_busy,
    input  wire                         rom_req,
    input  wire m92_mem_pkg::sdr_addr_t rom_addr,
    input  wire m92_mem_pkg::sdr_data_t rom_data,
    input  wire m92_mem_pkg::sdr_be_t   rom_be,
    input  wire m92_mem_pkg::sdr_addr_t cpu_addr,
    input  wire                         cpu_req,
    output logic                        cpu_rdy,
    input  wire m92_mem_pkg::sdr_addr_t hs_sdr_addr,
    input  wire m92_mem_pkg::sdr_be_t   hs_sdr_be,
    input  wire m92_mem_pkg::sdr_data_t hs_sdr_din,
    input  wire                         hs_rq,
    output logic                        hs_ack,
    output wire m92_mem_pkg::sdr_addr_t sdr_ch3_addr,
    output wire m92_mem_pkg::sdr_data_t sdr_ch3_din,
    output wire m92_mem_pkg::sdr_be_t   sdr_ch3_be,
    output wire                         sdr_ch3_rnw,
    output wire                         sdr_ch3_req,
    input  wire                         sdr_ch3_ready
);

    m92_mem_pkg::ch3_owner_t owner;
    m92_mem_pkg::sdr_addr_t  req_addr;
    m92_mem_pkg::sdr_data_t  req_din;
    m92_mem_pkg::sdr_be_t    req_be;
    logic issue;
    logic cpu_pend;
    logic hs_new;
    logic cpu_want;
    logic accept_hs;
    logic accept_cpu;
    logic finish;

    assign hs_new     = hs_rq != hs_ack;
    assign cpu_want   = cpu_req || cpu_pend;
    // Hiscore wins a tie
    assign accept_hs  = (owner == m92_mem_pkg::OWN_IDLE) && !rom_load_busy && hs_new;
    assign accept_cpu = (owner == m92_mem_pkg::OWN_IDLE) && !rom_load_busy
                        && !hs_new && cpu_want;
    assign finish     = (owner != m92_mem_pkg::OWN_IDLE) && !issue && sdr_ch3_ready;

    //////////////////////////////////////////////////////////////////////////
    // Owner FSM
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            owner    <= m92_mem_pkg::OWN_IDLE;
            issue    <= 1'b0;
            cpu_pend <= 1'b0;
            cpu_rdy  <= 1'b0;
            hs_ack   <= 1'b0;
        end else begin
            issue    <= accept_hs || accept_cpu;
            cpu_pend <= cpu_want && !accept_cpu;
            cpu_rdy  <= 1'b0;
            case (owner)
                m92_mem_pkg::OWN_IDLE: begin
                    if (accept_hs) begin
                        owner <= m92_mem_pkg::OWN_HS;
                    end else if (accept_cpu) begin
                        owner <= m92_mem_pkg::OWN_CPU;
                    end
                end
                m92_mem_pkg::OWN_HS: begin
                    if (finish) begin
                        hs_ack <= hs_rq;
                        owner  <= m92_mem_pkg::OWN_IDLE;
                    end
                end
                m92_mem_pkg::OWN_CPU: begin
                    if (finish) begin
                        cpu_rdy <= 1'b1;
                        owner   <= m92_mem_pkg::OWN_IDLE;
                    end
                end
                default: owner <= m92_mem_pkg::OWN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept_hs) begin
            req_addr <= hs_sdr_addr;
            req_be   <= hs_sdr_be;
            req_din  <= hs_sdr_din;
        end else if (accept_cpu) begin
            // CPU side only reads
            req_addr <= cpu_addr;
            req_be   <= 2'b00;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Channel outputs, the ROM loader bypasses the FSM
    //////////////////////////////////////////////////////////////////////////

    assign sdr_ch3_addr = rom_load_busy ? rom_addr : req_addr;
    assign sdr_ch3_din  = rom_load_busy ? rom_data : req_din;
    assign sdr_ch3_be   = rom_load_busy ? rom_be : req_be;
    assign sdr_ch3_rnw  = rom_load_busy ? 1'b0 : (req_be == 2'b00);
    assign sdr_ch3_req  = rom_load_busy ? rom_req : issue;

    a_one_outstanding : assert property (@(posedge clk_sys) disable iff (!rst_n)
        issue |=> (!issue until sdr_ch3_ready))
        else $error("channel 3 request while a cycle is outstanding");

    // The CPU holds the channel from its request cycle up to the ready
    a_cpu_rdy_owner : assert property (@(posedge clk_sys) disable iff (!rst_n)
        cpu_rdy |-> $past(owner == m92_mem_pkg::OWN_CPU, 2))
        else $error("cpu_rdy without CPU ownership");

endmodule

`default_nettype wire

/* source/m92_board_glue.sv */
// Board glue top level around the M92 core
// DIP decoder, input mapper, hiscore bridge and channel 3 arbiter
`timescale 1ns/1ps
`default_nettype none

`include "m92_defines.svh"

module m92_board_glue (
    input  wire                          clk_sys,
    input  wire                          rst_n,
    input  wire                          ioctl_wr,
    input  wire m92_mem_pkg::byte_t      ioctl_index,
    input  wire m92_mem_pkg::sdr_addr_t  ioctl_addr,
    input  wire m92_mem_pkg::byte_t      ioctl_dout,
    output wire [`M92_DIP_BANKS*8-1:0]   dip_sw,
    input  wire m92_input_pkg::pad_t     joystick_p1,
    input  wire m92_input_pkg::pad_t     joystick_p2,
    input  wire m92_input_pkg::pad_t     joystick_p3,
    input  wire m92_input_pkg::pad_t     joystick_p4,
    input  wire m92_input_pkg::pad_t     keyboard_p1,
    input  wire m92_input_pkg::pad_t     keyboard_p2,
    input  wire m92_input_pkg::pad_t     keyboard_p3,
    input  wire m92_input_pkg::pad_t     keyboard_p4,
    input  wire [3:0]                    key_start,
    input  wire [3:0]                    key_coin,
    input  wire                          key_pause,
    output wire m92_input_pkg::player_t  p1_input,
    output wire m92_input_pkg::player_t  p2_input,
    output wire m92_input_pkg::player_t  p3_input,
    output wire m92_input_pkg::player_t  p4_input,
    output wire [3:0]                    start_buttons,
    output wire                          coin,
    output wire                          pause,
    input  wire                          rom_load_busy,
    input  wire                          rom_req,
    input  wire m92_mem_pkg::sdr_addr_t  rom_addr,
    input  wire m92_mem_pkg::sdr_data_t  rom_data,
    input  wire m92_mem_pkg::sdr_be_t    rom_be,
    input  wire m92_mem_pkg::sdr_addr_t  cpu_addr,
    input  wire                          cpu_req,
    output wire                          cpu_rdy,
    input  wire m92_mem_pkg::hs_addr_t   hs_address,
    input  wire m92_mem_pkg::byte_t      hs_data_in,
    input  wire                          hs_read_enable,
    input  wire                          hs_write_enable,
    output wire m92_mem_pkg::byte_t      hs_data_out,
    output wire                          hs_data_ready,
    output wire m92_mem_pkg::sdr_addr_t  sdr_ch3_addr,
    output wire m92_mem_pkg::sdr_data_t  sdr_ch3_din,
    output wire m92_mem_pkg::sdr_be_t    sdr_ch3_be,
    output wire                          sdr_ch3_rnw,
    output wire                          sdr_ch3_req,
    input  wire                          sdr_ch3_ready,
    input  wire m92_mem_pkg::sdr_data_t  sdr_ch3_dout
);

    // Hiscore request between bridge and arbiter
    m92_mem_pkg::sdr_addr_t hs_sdr_addr;
    m92_mem_pkg::sdr_be_t   hs_sdr_be;
    m92_mem_pkg::sdr_data_t hs_sdr_din;
    logic                   hs_rq;
    logic                   hs_ack;

    ioctl_dip_decoder u_dip (
        .clk_sys, .rst_n, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout, .dip_sw
    );

    arcade_input_mapper u_inputs (
        .clk_sys, .rst_n,
        .joystick_p1, .joystick_p2, .joystick_p3, .joystick_p4,
        .keyboard_p1, .keyboard_p2, .keyboard_p3, .keyboard_p4,
        .key_start, .key_coin, .key_pause,
        .p1_input, .p2_input, .p3_input, .p4_input,
        .start_buttons, .coin, .pause
    );

    hiscore_ram_bridge u_hs_bridge (
        .clk_sys, .rst_n, .hs_address, .hs_data_in, .hs_read_enable, .hs_write_enable,
        .hs_data_out, .hs_data_ready, .hs_sdr_addr, .hs_sdr_be, .hs_sdr_din,
        .hs_rq, .hs_ack, .sdr_ch3_dout
    );

    sdram_ch3_arbiter u_ch3_arb (
        .clk_sys, .rst_n, .rom_load_busy, .rom_req, .rom_addr, .rom_data, .rom_be,
        .cpu_addr, .cpu_req, .cpu_rdy, .hs_sdr_addr, .hs_sdr_be, .hs_sdr_din,
        .hs_rq, .hs_ack, .sdr_ch3_addr, .sdr_ch3_din, .sdr_ch3_be, .sdr_ch3_rnw,
        .sdr_ch3_req, .sdr_ch3_ready
    );

endmodule

`default_nettype wire

/* verification/m92_board_glue_tb.sv */
// Directed testbench for the M92 board glue
// DIP capture, input mapping, ROM loading, hiscore accesses and CPU sharing,
// with a behavioral model of SDRAM channel 3
`timescale 1ns/1ps
`default_nettype none

`include "m92_defines.svh"

module m92_board_glue_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int STROBE_TIMEOUT = 20;
    localparam int MAP_ROUNDS     = 8;
    localparam int ROM_WORDS      = 4;
    localparam int CPU_WINDOW     = 16;
    // Drive, accept, issue, up to six cycles of latency and completion
    localparam int ACCESS_CYCLES  = 14;
    localparam int TEST_CYCLES    = 3 + 2 * (`M92_DIP_BANKS + 2) + 4 + MAP_ROUNDS * 2
                                    + ROM_WORDS * ACCESS_CYCLES + 3 * ACCESS_CYCLES
                                    + 2 * ACCESS_CYCLES + CPU_WINDOW;

    int seed = 75874;
    int fail_count = 0;

    logic clk_sys = 1'b0;
    logic rst_n;
    logic ioctl_wr;
    m92_mem_pkg::byte_t ioctl_index;
    m92_mem_pkg::sdr_addr_t ioctl_addr;
    m92_mem_pkg::byte_t ioctl_dout;
    logic [`M92_DIP_BANKS*8-1:0] dip_sw;
    m92_input_pkg::pad_t joystick_p1, joystick_p2, joystick_p3, joystick_p4;
    m92_input_pkg::pad_t keyboard_p1, keyboard_p2, keyboard_p3, keyboard_p4;
    logic [3:0] key_start;
    logic [3:0] key_coin;
    logic key_pause;
    m92_input_pkg::player_t p1_input, p2_input, p3_input, p4_input;
    logic [3:0] start_buttons;
    logic coin;
    logic pause;
    logic rom_load_busy;
    logic rom_req;
    m92_mem_pkg::sdr_addr_t rom_addr;
    m92_mem_pkg::sdr_data_t rom_data;
    m92_mem_pkg::sdr_be_t rom_be;
    m92_mem_pkg::sdr_addr_t cpu_addr;
    logic cpu_req;
    logic cpu_rdy;
    m92_mem_pkg::hs_addr_t hs_address;
    m92_mem_pkg::byte_t hs_data_in;
    logic hs_read_enable;
    logic hs_write_enable;
    m92_mem_pkg::byte_t hs_data_out;
    logic hs_data_ready;
    m92_mem_pkg::sdr_addr_t sdr_ch3_addr;
    m92_mem_pkg::sdr_data_t sdr_ch3_din;
    m92_mem_pkg::sdr_be_t sdr_ch3_be;
    logic sdr_ch3_rnw;
    logic sdr_ch3_req;
    logic sdr_ch3_ready;
    m92_mem_pkg::sdr_data_t sdr_ch3_dout;

    // SDRAM model state
    logic [15:0] model_mem [0:65535];
    m92_mem_pkg::sdr_addr_t lat_addr;
    int lat_cnt;

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    m92_board_glue DUT (
        .clk_sys, .rst_n, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout, .dip_sw,
        .joystick_p1, .joystick_p2, .joystick_p3, .joystick_p4,
        .keyboard_p1, .keyboard_p2, .keyboard_p3, .keyboard_p4,
        .key_start, .key_coin, .key_pause,
        .p1_input, .p2_input, .p3_input, .p4_input, .start_buttons, .coin, .pause,
        .rom_load_busy, .rom_req, .rom_addr, .rom_data, .rom_be,
        .cpu_addr, .cpu_req, .cpu_rdy,
        .hs_address, .hs_data_in, .hs_read_enable, .hs_write_enable,
        .hs_data_out, .hs_data_ready,
        .sdr_ch3_addr, .sdr_ch3_din, .sdr_ch3_be, .sdr_ch3_rnw, .sdr_ch3_req,
        .sdr_ch3_ready, .sdr_ch3_dout
    );

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM channel 3 model
    ////////////////////////////////////////////////////////////////////////////

    // Writes land at the request, reads return the word at ready time
    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sdr_ch3_ready <= 1'b0;
            lat_cnt       <= 0;
        end else begin
            sdr_ch3_ready <= 1'b0;
            if (sdr_ch3_req) begin
                lat_addr <= sdr_ch3_addr;
                lat_cnt  <= 1 + ($unsigned($random(seed)) % 6);
                if (!sdr_ch3_rnw && sdr_ch3_be[1]) begin
                    model_mem[sdr_ch3_addr[16:1]][15:8] <= sdr_ch3_din[15:8];
                end
                if (!sdr_ch3_rnw && sdr_ch3_be[0]) begin
                    model_mem[sdr_ch3_addr[16:1]][7:0] <= sdr_ch3_din[7:0];
                end
            end else if (lat_cnt == 1) begin
                sdr_ch3_ready <= 1'b1;
                sdr_ch3_dout  <= model_mem[lat_addr[16:1]];
                lat_cnt       <= 0;
            end else if (lat_cnt > 1) begin
                lat_cnt <= lat_cnt - 1;
            end
        end
    end

    function automatic logic [15:0] fill_word(input int idx);
        return ~idx[15:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking and waiting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        fail_count++;
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0t ns %s: got %0h, expected %0h",
                                     $time, name, got, exp));
        end
    endtask

    function automatic logic strobe_level(input string name);
        if (name == "sdr_ch3_req") begin
            return sdr_ch3_req;
        end else if (name == "sdr_ch3_ready") begin
            return sdr_ch3_ready;
        end else if (name == "hs_data_ready") begin
            return hs_data_ready;
        end
        return 1'b0;
    endfunction

    // Returns at the falling edge where the strobe is seen high
    task automatic wait_for_strobe(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk_sys);
        while (!strobe_level(name)) begin
            cycles++;
            if (cycles > STROBE_TIMEOUT) begin
                report_failure($sformatf("Timed out after %0d cycles waiting for %s",
                                         cycles, name));
            end
            @(negedge clk_sys);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_ioctl(input logic [7:0] index, input logic [24:0] addr,
                               input logic [7:0] data);
        @(posedge clk_sys);
        ioctl_wr    <= 1'b1;
        ioctl_index <= index;
        ioctl_addr  <= addr;
        ioctl_dout  <= data;
        @(posedge clk_sys);
        ioctl_wr    <= 1'b0;
    endtask

    // One-cycle enable pulse gives the bridge its rising edge
    task automatic start_hs_access(input logic wr, input logic [19:0] addr,
                                   input logic [7:0] data);
        @(posedge clk_sys);
        hs_address <= addr;
        hs_data_in <= data;
        if (wr) begin
            hs_write_enable <= 1'b1;
        end else begin
            hs_read_enable <= 1'b1;
        end
        @(posedge clk_sys);
        hs_write_enable <= 1'b0;
        hs_read_enable  <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic capture_dip_banks();
        logic [`M92_DIP_BANKS*8-1:0] expected;
        logic [7:0] value;
        expected = '1;
        @(negedge clk_sys);
        check_value("dip_sw", dip_sw, expected);
        for (int b = 0; b < `M92_DIP_BANKS; b++) begin
            value = $random(seed);
            write_ioctl(8'd254, 25'(b), value);
            expected[b*8 +: 8] = value;
            @(negedge clk_sys);
            check_value("dip_sw", dip_sw, expected);
        end
        // Out of range address, then a foreign download index
        write_ioctl(8'd254, 25'd5, ~expected[15:8]);
        write_ioctl(8'd92, 25'd0, ~expected[7:0]);
        @(negedge clk_sys);
        check_value("dip_sw", dip_sw, expected);
    endtask

    task automatic map_random_inputs();
        logic [15:0] comb;
        logic [3:0] exp_start;
        for (int r = 0; r < MAP_ROUNDS; r++) begin
            @(posedge clk_sys);
            joystick_p1 <= $random(seed);
            joystick_p2 <= $random(seed);
            joystick_p3 <= $random(seed);
            joystick_p4 <= $random(seed);
            keyboard_p1 <= $random(seed);
            keyboard_p2 <= $random(seed);
            keyboard_p3 <= $random(seed);
            keyboard_p4 <= $random(seed);
            key_start   <= $random(seed);
            key_coin    <= $random(seed);
            key_pause   <= $random(seed);
            @(posedge clk_sys);
            @(negedge clk_sys);
            comb = joystick_p1 | joystick_p2 | joystick_p3 | joystick_p4;
            exp_start[0] = joystick_p1[10] | key_start[0];
            exp_start[1] = joystick_p2[10] | comb[12] | key_start[1];
            exp_start[2] = joystick_p3[10] | key_start[2];
            exp_start[3] = joystick_p4[10] | key_start[3];
            check_value("p1_input", p1_input, keyboard_p1[9:0] | joystick_p1[9:0]);
            check_value("p2_input", p2_input, keyboard_p2[9:0] | joystick_p2[9:0]);
            check_value("p3_input", p3_input, keyboard_p3[9:0] | joystick_p3[9:0]);
            check_value("p4_input", p4_input, keyboard_p4[9:0] | joystick_p4[9:0]);
            check_value("start_buttons", start_buttons, exp_start);
            check_value("coin", coin, comb[11] | (|key_coin));
            check_value("pause", pause, comb[13] | key_pause);
        end
    endtask

    task automatic load_rom_words();
        logic [15:0] words [ROM_WORDS];
        logic [24:0] base;
        base = 25'h1_8000;
        @(posedge clk_sys);
        rom_load_busy <= 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            words[i] = $random(seed);
            @(posedge clk_sys);
            rom_addr <= base + 25'(2 * i);
            rom_data <= words[i];
            rom_be   <= 2'b11;
            rom_req  <= 1'b1;
            @(negedge clk_sys);
            check_value("sdr_ch3_addr", sdr_ch3_addr, base + 25'(2 * i));
            check_value("sdr_ch3_din", sdr_ch3_din, words[i]);
            check_value("sdr_ch3_be", sdr_ch3_be, 2'b11);
            check_value("sdr_ch3_rnw", sdr_ch3_rnw, 1'b0);
            check_value("sdr_ch3_req", sdr_ch3_req, 1'b1);
            @(posedge clk_sys);
            rom_req <= 1'b0;
            wait_for_strobe("sdr_ch3_ready");
        end
        @(posedge clk_sys);
        rom_load_busy <= 1'b0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            check_value("model_mem", model_mem[base[16:1] + i], words[i]);
        end
    endtask

    task automatic write_read_hiscore();
        logic [19:0] addr;
        logic [7:0] data;
        logic [15:0] orig;
        addr = 20'h3_1235;
        data = $random(seed);
        orig = fill_word(addr[15:1]);
        start_hs_access(1'b1, addr, data);
        wait_for_strobe("sdr_ch3_req");
        check_value("sdr_ch3_addr", sdr_ch3_addr, {9'h00A, addr[15:0]});
        check_value("sdr_ch3_be", sdr_ch3_be, 2'b10);
        check_value("sdr_ch3_din", sdr_ch3_din, {data, data});
        check_value("sdr_ch3_rnw", sdr_ch3_rnw, 1'b0);
        wait_for_strobe("hs_data_ready");
        start_hs_access(1'b0, addr, 8'h00);
        wait_for_strobe("sdr_ch3_req");
        check_value("sdr_ch3_addr", sdr_ch3_addr, {9'h00A, addr[15:0]});
        check_value("sdr_ch3_be", sdr_ch3_be, 2'b00);
        check_value("sdr_ch3_rnw", sdr_ch3_rnw, 1'b1);
        wait_for_strobe("hs_data_ready");
        check_value("hs_data_out", hs_data_out, data);
        // Low byte of the same word
        start_hs_access(1'b0, addr ^ 20'h1, 8'h00);
        wait_for_strobe("hs_data_ready");
        check_value("hs_data_out", hs_data_out, orig[7:0]);
    endtask

    task automatic share_channel_with_cpu();
        logic [24:0] addr;
        int req_count;
        int rdy_count;
        int cycles;
        addr = 25'h0_4242;
        req_count = 0;
        rdy_count = 0;
        cycles = 0;
        start_hs_access(1'b0, 20'h0_0400, 8'h00);
        wait_for_strobe("sdr_ch3_req");
        @(posedge clk_sys);
        cpu_addr <= addr;
        cpu_req  <= 1'b1;
        @(posedge clk_sys);
        cpu_req  <= 1'b0;
        @(negedge clk_sys);
        while (!hs_data_ready) begin
            if (sdr_ch3_req) begin
                report_failure("CPU got a channel request before the hiscore access ended");
            end
            cycles++;
            if (cycles > STROBE_TIMEOUT) begin
                report_failure("Timed out waiting for hs_data_ready during the CPU test");
            end
            @(negedge clk_sys);
        end
        for (int n = 0; n < CPU_WINDOW; n++) begin
            if (sdr_ch3_req) begin
                req_count++;
                check_value("sdr_ch3_addr", sdr_ch3_addr, addr);
                check_value("sdr_ch3_rnw", sdr_ch3_rnw, 1'b1);
            end
            if (cpu_rdy) begin
                rdy_count++;
            end
            @(negedge clk_sys);
        end
        check_value("sdr_ch3_req count", req_count, 1);
        check_value("cpu_rdy count", rdy_count, 1);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired before the tests finished");
    end

    initial begin
        for (int i = 0; i < 65536; i++) begin
            model_mem[i] = fill_word(i);
        end
        rst_n           = 1'b0;
        ioctl_wr        = 1'b0;
        ioctl_index     = '0;
        ioctl_addr      = '0;
        ioctl_dout      = '0;
        joystick_p1     = '0;
        joystick_p2     = '0;
        joystick_p3     = '0;
        joystick_p4     = '0;
        keyboard_p1     = '0;
        keyboard_p2     = '0;
        keyboard_p3     = '0;
        keyboard_p4     = '0;
        key_start       = '0;
        key_coin        = '0;
        key_pause       = 1'b0;
        rom_load_busy   = 1'b0;
        rom_req         = 1'b0;
        rom_addr        = '0;
        rom_data        = '0;
        rom_be          = '0;
        cpu_addr        = '0;
        cpu_req         = 1'b0;
        hs_address      = '0;
        hs_data_in      = '0;
        hs_read_enable  = 1'b0;
        hs_write_enable = 1'b0;
        sdr_ch3_ready   = 1'b0;
        sdr_ch3_dout    = '0;
        repeat (3) @(posedge clk_sys);
        rst_n <= 1'b1;
        capture_dip_banks();
        map_random_inputs();
        load_rom_words();
        write_read_hiscore();
        share_channel_with_cpu();
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/m92_mem_pkg.sv
source/m92_input_pkg.sv
source/ioctl_dip_decoder.sv
source/arcade_input_mapper.sv
source/hiscore_ram_bridge.sv
source/sdram_ch3_arbiter.sv
source/m92_board_glue.sv
verification/m92_board_glue_tb.sv
